// ==== all.f ====
// Package first, then RTL bottom up
src/fsab_pkg.sv
src/fsab_seq.sv
src/fsab_fifo.sv
src/fsab_mem.sv
src/fsab_system.sv
// Testbench and bound checks
dv/fsab_system_assert.sv
dv/tb_fsab_system.sv

// ==== dv/fsab_system_assert.sv ====
`timescale 1ns/1ps

module fsab_system_assert (
	input logic fclk,
	input logic fclk_rst_b,
	input logic stall,
	input logic fsabo_valid,
	input logic fsabo_credit,
	input logic fsabi_valid,
	input fsab_pkg::fsab_rsp_t fsabi,
	input logic done
);

	// One failure tally per property
	int unsigned fail_credit = 0;
	int unsigned fail_over = 0;
	int unsigned fail_reset = 0;
	int unsigned fail_done = 0;
	int unsigned fail_drain = 0;
	int unsigned fail_hold = 0;
	int unsigned fail_cnt;

	int cred_model;	// Sequencer credit count rebuilt from bus traffic

	assign fail_cnt = fail_credit + fail_over + fail_reset + fail_done + fail_drain + fail_hold;

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b)
			cred_model <= fsab_pkg::FSAB_CREDITS;	// Full buffer's worth
		else
			cred_model <= cred_model - int'(fsabo_valid) + int'(fsabo_credit);
	end

	// Push only with credit in hand
	push_has_credit: assert property (@(posedge fclk) disable iff (!fclk_rst_b)
		fsabo_valid |-> cred_model > 0) else begin
		$error("push while credit count is zero");
		fail_credit++;
	end

	credit_bounded: assert property (@(posedge fclk) disable iff (!fclk_rst_b)
		cred_model <= fsab_pkg::FSAB_CREDITS) else begin
		$error("credit count above buffer depth");
		fail_over++;
	end

	// Outputs quiet while in reset
	reset_quiet: assert property (@(posedge fclk)
		!fclk_rst_b |-> !fsabi_valid && !done) else begin
		$error("response valid or done high during reset");
		fail_reset++;
	end

	done_sticky: assert property (@(posedge fclk) disable iff (!fclk_rst_b)
		done |=> done) else begin
		$error("done fell after rising");
		fail_done++;
	end

	// Done only once every credit is back
	done_drained: assert property (@(posedge fclk) disable iff (!fclk_rst_b)
		done |-> cred_model == fsab_pkg::FSAB_CREDITS) else begin
		$error("done high with credits still outstanding");
		fail_drain++;
	end

	// Stalled cycle leaves the response beat in place
	rsp_held: assert property (@(posedge fclk) disable iff (!fclk_rst_b)
		stall |=> $stable(fsabi)) else begin
		$error("response beat changed during stall");
		fail_hold++;
	end

endmodule

bind fsab_system fsab_system_assert u_assert (
	.fclk (fclk),
	.fclk_rst_b (fclk_rst_b),
	.stall (stall),
	.fsabo_valid (fsabo_valid),
	.fsabo_credit (fsabo_credit),
	.fsabi_valid (fsabi_valid),
	.fsabi (fsabi),
	.done (done)
);

// ==== dv/tb_fsab_system.sv ====
`timescale 1ns/1ps

module tb_fsab_system;

	localparam int RST_CYCLES = 8;
	localparam int REQ_BEATS = 13;	// 8 write beats, 2 single writes, 3 read headers
	localparam int RSP_BEATS = 24;	// Three eight-beat reads
	localparam int SETTLE_CYCLES = 20;	// Watch for stray beats after the last
	// Generous per-beat allowance covers stall bursts
	localparam int WATCHDOG_CYCLES = 50 * (REQ_BEATS + RSP_BEATS) + RST_CYCLES;
	localparam logic [31:0] LCG_SEED = 32'h8c1ed833;

	logic fclk = 1'b0;
	logic fclk_rst_b;
	logic start;
	logic stall = 1'b0;
	logic fsabi_valid;
	fsab_pkg::fsab_rsp_t fsabi;
	logic done;

	// Stall generator
	logic [31:0] rnd = LCG_SEED;
	int burst_left = 40;	// Opening stall fills the buffer

	// Expected traffic
	logic [fsab_pkg::FSAB_DATA_W-1:0] shadow [fsab_pkg::MEM_WORDS];
	logic [fsab_pkg::FSAB_DATA_W-1:0] exp_data [$];
	logic [fsab_pkg::FSAB_DID_W-1:0] exp_subdid [$];
	int rx_cnt = 0;
	int rx_errs = 0;
	int end_errs = 0;

	fsab_system uut (
		.fclk (fclk),
		.fclk_rst_b (fclk_rst_b),
		.start (start),
		.stall (stall),
		.fsabi_valid (fsabi_valid),
		.fsabi (fsabi),
		.done (done)
	);

	always #2 fclk = ~fclk;	// 4 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_cycle();
		@(posedge fclk);
		#0.5;	// Drive clear of the edge
	endtask

	// Byte-enable merge into the shadow copy
	task automatic shadow_write(input int byte_addr, input int beat,
		input logic [fsab_pkg::FSAB_DATA_W-1:0] data,
		input logic [fsab_pkg::FSAB_MASK_W-1:0] mask);
		int idx;
		int i;
		idx = (byte_addr >> 3) + beat;	// Word index plus beat
		for (i = 0; i < fsab_pkg::FSAB_MASK_W; i++) begin
			if (mask[i])
				shadow[idx][i*8 +: 8] = data[i*8 +: 8];
		end
	endtask

	// Snapshot of a read at its place in script order
	task automatic expect_read(input int byte_addr, input int len,
		input logic [fsab_pkg::FSAB_DID_W-1:0] subdid);
		int k;
		for (k = 0; k < len; k++) begin
			exp_data.push_back(shadow[(byte_addr >> 3) + k]);
			exp_subdid.push_back(subdid);
		end
	endtask

	task automatic build_expected();
		logic [3:0] nib;
		int k;
		for (k = 0; k < fsab_pkg::MEM_WORDS; k++)
			shadow[k] = '0;	// Memory starts cleared
		for (k = 0; k < 8; k++) begin
			nib = 4'(8 - k);	// Descending nibble per beat
			shadow_write(0, k, {16{nib}}, 8'hFF);
		end
		expect_read(0, 8, 4'd1);
		shadow_write(8, 0, 64'h1EA7_5417_1EA7_5417, 8'hF0);	// High half of word 1
		expect_read(0, 8, 4'd2);
		shadow_write(4, 0, 64'h1337_1337_1337_1337, 8'h0F);	// Low half of word 0
		expect_read(0, 8, 4'd3);
	endtask

	task automatic finish_run(input logic timed_out);
		int assert_errs;
		assert_errs = int'(uut.u_assert.fail_cnt);
		$display("Errors: read checks %0d, end checks %0d, assertions %0d, timeout %0d",
			rx_errs, end_errs, assert_errs, int'(timed_out));
		if (rx_errs == 0 && end_errs == 0 && assert_errs == 0 && !timed_out)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	// Stall pattern, about a third high with long bursts
	always @(posedge fclk) begin
		#0.5;
		if (burst_left > 0) begin
			stall = 1'b1;
			burst_left--;
		end else begin
			rnd = lcg_next(rnd);
			if (rnd[31:27] == 5'd0) begin
				burst_left = 20 + int'(rnd[3:0]);	// 20 to 35 cycles
				stall = 1'b1;
			end else begin
				stall = (rnd[23:16] < 8'd80);
			end
		end
	end

	// Response beats sampled mid-cycle
	always @(negedge fclk) begin
		if (fclk_rst_b && fsabi_valid) begin
			assert (exp_data.size() > 0) else begin
				$display("CHECK FAILED at %0t: read beat %0d arrived with none expected",
					$time, rx_cnt);
				rx_errs++;
			end
			if (exp_data.size() > 0) begin
				assert (fsabi.data == exp_data[0] && fsabi.subdid == exp_subdid[0] &&
					fsabi.did == '0) else begin
					$display("CHECK FAILED at %0t: beat %0d did %0d subdid %0d data %h, %s %0d data %h",
						$time, rx_cnt, fsabi.did, fsabi.subdid, fsabi.data,
						"expected did 0 subdid", exp_subdid[0], exp_data[0]);
					rx_errs++;
				end
				void'(exp_data.pop_front());
				void'(exp_subdid.pop_front());
			end
			rx_cnt++;
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fclk);
		$display("Timeout after %0d cycles with %0d of %0d read beats received",
			WATCHDOG_CYCLES, rx_cnt, RSP_BEATS);
		if (!done)
			$display("The done flag never rose");
		foreach (exp_subdid[i])
			$display("Read beat %0d of subdid %0d never arrived", rx_cnt + i, exp_subdid[i]);
		finish_run(1'b1);
	end

	initial begin
		fclk_rst_b = 1'b0;
		start = 1'b0;
		build_expected();
		repeat (RST_CYCLES) @(posedge fclk);
		#0.5;
		fclk_rst_b = 1'b1;
		assert (!fsabi_valid && !done) else begin
			$display("CHECK FAILED at %0t: outputs active straight after reset", $time);
			end_errs++;
		end
		next_cycle();
		start = 1'b1;	// Held two cycles for the synchronizer
		next_cycle();
		next_cycle();
		start = 1'b0;
		while (!(done && rx_cnt == RSP_BEATS))
			next_cycle();
		repeat (SETTLE_CYCLES)
			next_cycle();
		assert (rx_cnt == RSP_BEATS && exp_data.size() == 0) else begin
			$display("CHECK FAILED at %0t: %0d read beats received, expected %0d",
				$time, rx_cnt, RSP_BEATS);
			end_errs++;
		end
		assert (done) else begin
			$display("CHECK FAILED at %0t: done low at end of run", $time);
			end_errs++;
		end
		finish_run(1'b0);
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the FSAB exerciser testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_fsab_system
BUILD_DIR=obj_dir
PASS_LINE="Done: no errors"

# Build the simulation model
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

# Run it, let bound assertion errors be counted instead of stopping
output=$("./$BUILD_DIR/V$TOP" +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Verdict comes from the testbench's closing message
if echo "$output" | grep -Fqx "$PASS_LINE"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

// ==== src/fsab_fifo.sv ====
`timescale 1ns/1ps

module fsab_fifo (
	input logic fclk,
	input logic fclk_rst_b,
	input logic push,
	input fsab_pkg::fsab_req_t push_beat,
	input logic pop,
	output fsab_pkg::fsab_req_t head,
	output logic not_empty,
	output logic credit
);

	fsab_pkg::fsab_req_t store [fsab_pkg::FSAB_CREDITS];	// Circular beat store
	fsab_pkg::fsab_ptr_t wr_ptr;
	fsab_pkg::fsab_ptr_t rd_ptr;
	fsab_pkg::fsab_cred_t count;	// Occupancy 0..FSAB_CREDITS
	logic pop_ok;

	// Wrap at depth, also for depths that are not a power of two
	function automatic fsab_pkg::fsab_ptr_t ptr_inc(input fsab_pkg::fsab_ptr_t p);
		return (p == fsab_pkg::fsab_ptr_t'(fsab_pkg::FSAB_CREDITS - 1)) ?
			'0 : p + fsab_pkg::fsab_ptr_t'(1);
	endfunction

	assign not_empty = (count != '0);
	assign pop_ok = pop && not_empty;	// Never pop an empty store
	assign head = store[rd_ptr];

	// Credits guarantee room, push is never refused
	always_ff @(posedge fclk) begin
		if (push)
			store[wr_ptr] <= push_beat;
	end

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop_ok;	// One pulse a cycle after each pop
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop_ok)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop_ok})
				2'b10: count <= count + fsab_pkg::fsab_cred_t'(1);
				2'b01: count <= count - fsab_pkg::fsab_cred_t'(1);
				default: ;	// Push and pop together keep level
			endcase
		end
	end

endmodule

// ==== src/fsab_mem.sv ====
`timescale 1ns/1ps

module fsab_mem (
	input logic fclk,
	input logic fclk_rst_b,
	input logic stall,
	input fsab_pkg::fsab_req_t head,
	input logic not_empty,
	output logic pop,
	output logic fsabi_valid,
	output fsab_pkg::fsab_rsp_t fsabi
);

	typedef enum logic [1:0] {
		M_IDLE,	// Waiting for a header beat
		M_WRITE,	// Rest of a write burst
		M_READ	// Streaming read beats
	} mem_state_t;

	mem_state_t state;
	fsab_pkg::fsab_len_t beat_cnt;	// Zero whenever idle
	fsab_pkg::mem_idx_t wr_idx;
	fsab_pkg::mem_idx_t rd_idx;
	logic head_last;
	logic rd_last;

	// Latched read request
	fsab_pkg::mem_idx_t rd_base;
	fsab_pkg::fsab_len_t rd_len;
	logic [fsab_pkg::FSAB_DID_W-1:0] rd_did;
	logic [fsab_pkg::FSAB_DID_W-1:0] rd_subdid;

	// Word array, starts cleared
	logic [fsab_pkg::FSAB_DATA_W-1:0] mem_q [fsab_pkg::MEM_WORDS] = '{default: '0};

	// Nothing taken during a read stream or a stall
	assign pop = not_empty && !stall && (state != M_READ);

	// Base word from byte address, plus beat within burst
	assign wr_idx = fsab_pkg::mem_idx_t'(head.addr[fsab_pkg::FSAB_ADDR_W-1:fsab_pkg::BEAT_SHIFT])
		+ fsab_pkg::mem_idx_t'(beat_cnt);
	assign rd_idx = rd_base + fsab_pkg::mem_idx_t'(beat_cnt);
	assign head_last = (beat_cnt == head.len - fsab_pkg::fsab_len_t'(1));
	assign rd_last = (beat_cnt == rd_len - fsab_pkg::fsab_len_t'(1));

	// Byte masked merge, stored in the pop cycle
	always @(posedge fclk) begin
		if (pop && head.mode == fsab_pkg::FSAB_WRITE) begin
			for (int i = 0; i < fsab_pkg::FSAB_MASK_W; i++) begin
				if (head.mask[i])
					mem_q[wr_idx][i*8 +: 8] <= head.data[i*8 +: 8];
			end
		end
	end

	// Header fields for the stream
	always_ff @(posedge fclk) begin
		if (pop && state == M_IDLE && head.mode == fsab_pkg::FSAB_READ) begin
			rd_base <= wr_idx;	// beat_cnt is zero here
			rd_len <= head.len;
			rd_did <= head.did;
			rd_subdid <= head.subdid;
		end
	end

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b) begin
			state <= M_IDLE;
			beat_cnt <= '0;
			fsabi_valid <= 1'b0;
			fsabi <= '0;
		end else begin
			fsabi_valid <= 1'b0;
			case (state)
				M_IDLE: begin
					if (pop) begin
						if (head.mode == fsab_pkg::FSAB_READ) begin
							state <= M_READ;
						end else if (!head_last) begin
							state <= M_WRITE;	// More beats follow
							beat_cnt <= beat_cnt + fsab_pkg::fsab_len_t'(1);
						end
					end
				end
				M_WRITE: begin
					if (pop) begin
						if (head_last) begin
							state <= M_IDLE;
							beat_cnt <= '0;
						end else begin
							beat_cnt <= beat_cnt + fsab_pkg::fsab_len_t'(1);
						end
					end
				end
				M_READ: begin
					if (!stall) begin	// Beat and data hold while stalled
						fsabi_valid <= 1'b1;
						fsabi <= '{did: rd_did, subdid: rd_subdid, data: mem_q[rd_idx]};
						if (rd_last) begin
							state <= M_IDLE;
							beat_cnt <= '0;
						end else begin
							beat_cnt <= beat_cnt + fsab_pkg::fsab_len_t'(1);
						end
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

endmodule

// ==== src/fsab_pkg.sv ====
package fsab_pkg;

	// Bus widths
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;	// One enable per data byte
	localparam int FSAB_ADDR_W = 31;	// Byte address
	localparam int FSAB_LEN_W = 4;	// 1 to 8 beats
	localparam int FSAB_DID_W = 4;

	// Beat buffer depth, also the sequencer's starting credit
	localparam int FSAB_CREDITS = 8;

	// Behavioural memory
	localparam int MEM_WORDS = 64;

	// Derived widths
	localparam int FSAB_CRED_W = $clog2(FSAB_CREDITS + 1);	// Holds 0 to FSAB_CREDITS
	localparam int FSAB_PTR_W = $clog2(FSAB_CREDITS);
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int BEAT_SHIFT = $clog2(FSAB_MASK_W);	// Byte address to word index

	typedef logic [FSAB_CRED_W-1:0] fsab_cred_t;
	typedef logic [FSAB_PTR_W-1:0] fsab_ptr_t;
	typedef logic [FSAB_LEN_W-1:0] fsab_len_t;
	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

	localparam fsab_cred_t FSAB_CRED_FULL = fsab_cred_t'(FSAB_CREDITS);

	typedef enum logic {
		FSAB_READ = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	// Outbound beat, header repeats on every beat of a burst
	typedef struct packed {
		fsab_mode_t mode;
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		fsab_len_t len;
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
	} fsab_req_t;

	// Inbound read beat
	typedef struct packed {
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_DATA_W-1:0] data;
	} fsab_rsp_t;

endpackage

// ==== src/fsab_seq.sv ====
`timescale 1ns/1ps

module fsab_seq (
	input logic fclk,
	input logic fclk_rst_b,
	input logic start,
	input logic fsabo_credit,
	output logic fsabo_valid,
	output fsab_pkg::fsab_req_t fsabo,
	output logic done
);

	// Script order, requests advance by one
	typedef enum logic [3:0] {
		S_IDLE,
		S_WR_BURST,	// 8 beats to 0x0
		S_RD_A,	// Read 8 from 0x0, tag 1
		S_WR_HI,	// High half of word 1
		S_RD_B,	// Tag 2
		S_WR_LO,	// Low half of word 0
		S_RD_C,	// Tag 3
		S_DRAIN,	// Wait for all credits
		S_DONE
	} seq_state_t;

	seq_state_t state;
	logic [1:0] start_sync;	// Two flop synchronizer
	fsab_pkg::fsab_cred_t credit_cnt;
	fsab_pkg::fsab_len_t beat_cnt;	// Beat within write burst
	logic [3:0] nibble;
	logic req_active;	// State carries a request
	logic last_beat;

	// Request decode from state
	always_comb begin
		fsabo = '0;	// Tags zero, mode read
		fsabo.len = fsab_pkg::fsab_len_t'(1);
		req_active = 1'b1;
		nibble = 4'd8 - beat_cnt;	// Descending pattern 8..1
		case (state)
			S_WR_BURST: begin
				fsabo.mode = fsab_pkg::FSAB_WRITE;
				fsabo.len = fsab_pkg::fsab_len_t'(8);
				fsabo.data = {16{nibble}};
				fsabo.mask = 8'hFF;
			end
			S_RD_A: begin
				fsabo.len = fsab_pkg::fsab_len_t'(8);
				fsabo.subdid = 4'd1;
			end
			S_WR_HI: begin
				fsabo.mode = fsab_pkg::FSAB_WRITE;
				fsabo.addr = 31'h8;
				fsabo.data = 64'h1EA754171EA75417;
				fsabo.mask = 8'hF0;	// Upper four bytes only
			end
			S_RD_B: begin
				fsabo.len = fsab_pkg::fsab_len_t'(8);
				fsabo.subdid = 4'd2;
			end
			S_WR_LO: begin
				fsabo.mode = fsab_pkg::FSAB_WRITE;
				fsabo.addr = 31'h4;	// Still word 0
				fsabo.data = 64'h1337133713371337;
				fsabo.mask = 8'h0F;
			end
			S_RD_C: begin
				fsabo.len = fsab_pkg::fsab_len_t'(8);
				fsabo.subdid = 4'd3;
			end
			default: req_active = 1'b0;
		endcase
		// Read header is one beat whatever its len
		last_beat = (fsabo.mode == fsab_pkg::FSAB_READ) ||
			(beat_cnt == fsabo.len - fsab_pkg::fsab_len_t'(1));
	end

	assign fsabo_valid = req_active && (credit_cnt != '0);	// Hold when out of credit
	assign done = (state == S_DONE);

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b) begin
			state <= S_IDLE;
			start_sync <= 2'b00;
			credit_cnt <= fsab_pkg::FSAB_CRED_FULL;
			beat_cnt <= '0;
		end else begin
			start_sync <= {start_sync[0], start};

			// One credit per push, one back per pop
			case ({fsabo_credit, fsabo_valid})
				2'b10: credit_cnt <= credit_cnt + fsab_pkg::fsab_cred_t'(1);
				2'b01: credit_cnt <= credit_cnt - fsab_pkg::fsab_cred_t'(1);
				default: ;	// Both or neither
			endcase

			case (state)
				S_IDLE: begin
					if (start_sync[1])
						state <= S_WR_BURST;
				end
				S_DRAIN: begin
					if (credit_cnt == fsab_pkg::FSAB_CRED_FULL)
						state <= S_DONE;	// Buffer fully drained
				end
				S_DONE: ;	// Sticky until reset
				default: begin
					if (fsabo_valid) begin
						if (last_beat) begin
							beat_cnt <= '0;
							state <= seq_state_t'(state + 4'd1);	// Next script entry
						end else begin
							beat_cnt <= beat_cnt + fsab_pkg::fsab_len_t'(1);
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== src/fsab_system.sv ====
`timescale 1ns/1ps

module fsab_system (
	input logic fclk,
	input logic fclk_rst_b,
	input logic start,
	input logic stall,	// Refresh and controller back-pressure
	output logic fsabi_valid,
	output fsab_pkg::fsab_rsp_t fsabi,
	output logic done
);

	// Outbound request path
	logic fsabo_valid;
	fsab_pkg::fsab_req_t fsabo;
	logic fsabo_credit;

	// Buffer to memory
	fsab_pkg::fsab_req_t fifo_head;
	logic fifo_not_empty;
	logic mem_pop;

	fsab_seq u_seq (
		.fclk (fclk),
		.fclk_rst_b (fclk_rst_b),
		.start (start),
		.fsabo_credit (fsabo_credit),
		.fsabo_valid (fsabo_valid),
		.fsabo (fsabo),
		.done (done)
	);

	fsab_fifo u_fifo (
		.fclk (fclk),
		.fclk_rst_b (fclk_rst_b),
		.push (fsabo_valid),	// Every valid beat is a push
		.push_beat (fsabo),
		.pop (mem_pop),
		.head (fifo_head),
		.not_empty (fifo_not_empty),
		.credit (fsabo_credit)
	);

	fsab_mem u_mem (
		.fclk (fclk),
		.fclk_rst_b (fclk_rst_b),
		.stall (stall),
		.head (fifo_head),
		.not_empty (fifo_not_empty),
		.pop (mem_pop),
		.fsabi_valid (fsabi_valid),
		.fsabi (fsabi)
	);

endmodule
